// File: all.f
src/eth_pkg.sv
src/fifo_if.sv
src/sync_fifo.sv
src/frame_seq_fsm.sv
src/frame_builder.sv
src/eth_readout.sv
tests/eth_readout_properties.sv
tests/eth_readout_checker.sv
tests/tb_eth_readout.sv

// File: src/eth_pkg.sv
`default_nettype none

package eth_pkg;

	localparam int SAMP_W = 12;
	localparam int L1A_W = 24;

	localparam int EVT_DEPTH = 128;
	localparam int L1A_DEPTH = 16;
	localparam int EVT_AMT_LVL = 4;
	localparam int EVT_AFL_LVL = 112;

	localparam logic [15:0] TRL_MARK = 16'h700C;
	localparam logic [15:0] END_MARK = 16'h7FFF;

	typedef struct packed {
		logic ovlp;
		logic [SAMP_W-1:0] data;
	} evt_word_t;

	typedef struct packed {
		logic phase;
		logic [L1A_W-1:0] num;
	} l1a_rec_t;

	// word order inside a frame
	typedef enum logic [2:0] {
		HDR_H,
		HDR_L,
		SAMP,
		CRC,
		TRL,
		STAT,
		END
	} word_sel_e;

	// one crc-15 step over 13 data bits
	function automatic logic [14:0] crc15_d13(input logic [12:0] d, input logic [14:0] c);
		logic [14:0] n;
		n[0] = d[0] ^ c[2];
		for (int i = 1; i <= 12; i++) begin
			n[i] = d[i-1] ^ d[i] ^ c[i+1] ^ c[i+2];
		end
		n[13] = d[12] ^ c[14] ^ c[0];
		n[14] = c[1];
		return n;
	endfunction

endpackage

`default_nettype wire

// File: src/eth_readout.sv
`default_nettype none
`timescale 1ns/1ps

module eth_readout import eth_pkg::*; (
	input logic RCLK,
	input logic RST_RESYNC,
	input logic [6:0] samp_max,
	input logic [12:0] wdata,
	input logic wren,
	input logic [24:0] l1a_data,
	input logic l1a_wren,
	input logic warn,
	input logic txack,
	output logic [15:0] txd,
	output logic txd_vld,
	output logic evt_buf_amt,
	output logic evt_buf_afl
);

	logic ce;
	word_sel_e word_sel;
	logic word_vld;
	logic crc_clr;

	fifo_if #(.T(evt_word_t)) evt_if ();
	fifo_if #(.T(l1a_rec_t)) l1a_if ();

	assign ce = txack; // transmitter paces the whole chain

	assign evt_if.push = wren;
	assign evt_if.wdata = wdata;
	assign l1a_if.push = l1a_wren;
	assign l1a_if.wdata = l1a_data;

	sync_fifo #(.T(evt_word_t), .DEPTH(EVT_DEPTH)) evt_fifo (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.port(evt_if.fifo),
		.almost_empty(evt_buf_amt),
		.almost_full(evt_buf_afl)
	);

	sync_fifo #(.T(l1a_rec_t), .DEPTH(L1A_DEPTH)) l1a_fifo (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.port(l1a_if.fifo),
		.almost_empty(),
		.almost_full()
	);

	frame_seq_fsm u_seq (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.ce(ce),
		.samp_max(samp_max),
		.l1a_rd(l1a_if.reader),
		.evt_rd(evt_if.reader),
		.word_sel(word_sel),
		.word_vld(word_vld),
		.crc_clr(crc_clr)
	);

	frame_builder u_build (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.ce(ce),
		.word_sel(word_sel),
		.word_vld(word_vld),
		.crc_clr(crc_clr),
		.l1a(l1a_if.rdata),
		.samp(evt_if.rdata),
		.warn(warn),
		.txd(txd),
		.txd_vld(txd_vld)
	);

endmodule

`default_nettype wire

// File: src/fifo_if.sv
`default_nettype none
`timescale 1ns/1ps

interface fifo_if #(
	parameter type T = logic
);
	logic push;
	T wdata;
	logic pop;
	T rdata; // head word, valid while !empty
	logic empty;
	logic full;

	modport writer (output push, output wdata, input full);

	modport reader (output pop, input rdata, input empty);

	modport fifo (input push, input wdata, input pop,
		output rdata, output empty, output full);

endinterface

`default_nettype wire

// File: src/frame_builder.sv
`default_nettype none
`timescale 1ns/1ps

module frame_builder import eth_pkg::*; (
	input logic RCLK,
	input logic RST_RESYNC,
	input logic ce,
	input word_sel_e word_sel,
	input logic word_vld,
	input logic crc_clr,
	input l1a_rec_t l1a,
	input evt_word_t samp,
	input logic warn,
	output logic [15:0] txd,
	output logic txd_vld
);

	logic [15:0] s1_form;
	logic [15:0] s1_word;
	word_sel_e s1_sel;
	logic s1_vld;
	logic [5:0] s1_l1a_lo;
	logic [14:0] crc;
	logic [4:0] frm_cnt;

	// stage one word, header halves or sample
	always_comb begin
		case (word_sel)
			HDR_H: s1_form = {4'h0, l1a.num[L1A_W-1:L1A_W/2]};
			HDR_L: s1_form = {4'h0, l1a.num[L1A_W/2-1:0]};
			default: s1_form = {1'b0, ~samp.ovlp, l1a.phase, 1'b0, samp.data};
		endcase
	end

	always_ff @(posedge RCLK) begin
		if (ce) begin
			s1_word <= s1_form;
			s1_l1a_lo <= l1a.num[5:0]; // for status word
			if (crc_clr)
				crc <= '0;
			else if (word_vld && word_sel == SAMP)
				crc <= crc15_d13({1'b0, samp.data}, crc);
		end
	end

	// stage two, frame-end substitution
	always_ff @(posedge RCLK) begin
		if (ce) begin
			case (s1_sel)
				CRC: txd <= {1'b0, crc};
				TRL: txd <= TRL_MARK;
				STAT: txd <= {4'h7, s1_l1a_lo, frm_cnt, warn};
				END: txd <= END_MARK;
				default: txd <= s1_word;
			endcase
		end
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			s1_vld <= 1'b0;
			s1_sel <= HDR_H;
			txd_vld <= 1'b0;
			frm_cnt <= '0;
		end else if (ce) begin
			s1_vld <= word_vld;
			s1_sel <= word_sel;
			txd_vld <= s1_vld;
			if (s1_vld && s1_sel == END)
				frm_cnt <= frm_cnt + 5'd1; // wraps at 32
		end
	end

endmodule

`default_nettype wire

// File: src/frame_seq_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module frame_seq_fsm import eth_pkg::*; (
	input logic RCLK,
	input logic RST_RESYNC,
	input logic ce,
	input logic [6:0] samp_max,
	fifo_if.reader l1a_rd,
	fifo_if.reader evt_rd,
	output word_sel_e word_sel,
	output logic word_vld,
	output logic crc_clr
);

	word_sel_e sel_q;
	word_sel_e sel_nxt;
	logic [6:0] samp_cnt;
	logic [6:0] samp_cnt_nxt;
	logic start;

	// idle is HDR_H with no trigger pending
	assign start = (sel_q == HDR_H) && !l1a_rd.empty;

	assign word_sel = sel_q;
	assign word_vld = (sel_q != HDR_H) || start;
	assign crc_clr = start; // fresh crc each frame

	assign evt_rd.pop = ce && (sel_q == SAMP);
	assign l1a_rd.pop = ce && (sel_q == END); // record done after end mark

	always_comb begin
		sel_nxt = sel_q;
		samp_cnt_nxt = samp_cnt;
		case (sel_q)
			HDR_H: begin
				if (start)
					sel_nxt = HDR_L;
			end
			HDR_L: begin
				sel_nxt = SAMP;
				samp_cnt_nxt = '0;
			end
			SAMP: begin
				if (samp_cnt == samp_max)
					sel_nxt = CRC; // samp_max+1 words sent
				else
					samp_cnt_nxt = samp_cnt + 7'd1;
			end
			CRC: begin
				sel_nxt = TRL;
			end
			TRL: begin
				sel_nxt = STAT;
			end
			STAT: begin
				sel_nxt = END;
			end
			END: begin
				sel_nxt = HDR_H;
			end
			default: begin
				sel_nxt = HDR_H;
			end
		endcase
	end

	// everything holds while the transmitter stalls
	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			sel_q <= HDR_H;
			samp_cnt <= '0;
		end else if (ce) begin
			sel_q <= sel_nxt;
			samp_cnt <= samp_cnt_nxt;
		end
	end

endmodule

`default_nettype wire

// File: src/sync_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module sync_fifo import eth_pkg::*; #(
	parameter type T = logic,
	parameter int DEPTH = 16,
	parameter int AMT_LVL = EVT_AMT_LVL,
	parameter int AFL_LVL = EVT_AFL_LVL
) (
	input logic RCLK,
	input logic RST_RESYNC,
	fifo_if.fifo port,
	output logic almost_empty,
	output logic almost_full
);

	T mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH):0] count;
	logic [$clog2(DEPTH):0] count_nxt;
	logic wr_ok;
	logic rd_ok;

	assign port.empty = (count == '0);
	assign port.full = (count == DEPTH);
	assign port.rdata = mem[rd_ptr]; // fall-through head

	assign wr_ok = port.push && !port.full;
	assign rd_ok = port.pop && !port.empty;

	always_comb begin
		count_nxt = count;
		if (wr_ok && !rd_ok)
			count_nxt = count + 1'b1;
		else if (rd_ok && !wr_ok)
			count_nxt = count - 1'b1;
	end

	always_ff @(posedge RCLK) begin
		if (wr_ok)
			mem[wr_ptr] <= port.wdata;
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			almost_empty <= 1'b1;
			almost_full <= 1'b0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_nxt;
			almost_empty <= (count_nxt <= AMT_LVL);
			almost_full <= (count_nxt >= AFL_LVL);
		end
	end

endmodule

`default_nettype wire

// File: tests/eth_readout_checker.sv
`default_nettype none
`timescale 1ns/1ps

module eth_readout_checker import eth_pkg::*; (
	input logic RCLK,
	input logic RST_RESYNC,
	input logic [6:0] samp_max,
	input evt_word_t wdata,
	input logic wren,
	input l1a_rec_t l1a_data,
	input logic l1a_wren,
	input logic warn,
	input logic txack,
	input logic [15:0] txd,
	input logic txd_vld,
	input logic evt_buf_amt,
	input logic evt_buf_afl,
	output int errors,
	output int frames_done
);

	evt_word_t samp_q[$];
	l1a_rec_t l1a_q[$];
	logic [16:0] exp_q[$]; // bit 16 marks a sample word
	logic [16:0] exp;
	logic [4:0] frm_cnt;
	int owed; // samples assigned to a frame, not yet seen on txd
	int hi;
	int hi_prev;

	task automatic build_frame();
		l1a_rec_t rec;
		evt_word_t s;
		logic [14:0] crc;
		rec = l1a_q.pop_front();
		crc = '0;
		exp_q.push_back({5'h0, rec.num[23:12]});
		exp_q.push_back({5'h0, rec.num[11:0]});
		for (int i = 0; i <= samp_max; i++) begin
			s = samp_q.pop_front();
			exp_q.push_back({2'b10, ~s.ovlp, rec.phase, 1'b0, s.data});
			crc = crc15_d13({1'b0, s.data}, crc);
		end
		exp_q.push_back({2'b00, crc});
		exp_q.push_back({1'b0, TRL_MARK});
		exp_q.push_back({5'h7, rec.num[5:0], frm_cnt, warn}); // status
		exp_q.push_back({1'b0, END_MARK});
		owed = owed + samp_max + 1;
		frm_cnt = frm_cnt + 5'd1;
	endtask

	always @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			samp_q.delete();
			l1a_q.delete();
			exp_q.delete();
			frm_cnt = '0;
			owed = 0;
			hi_prev = 0;
			frames_done <= 0;
		end else begin
			hi = samp_q.size() + owed;
			// at most two popped samples still in the output pipeline
			if (hi - 2 >= EVT_AFL_LVL && hi_prev - 2 >= EVT_AFL_LVL && !evt_buf_afl) begin
				$display("** Error at %0t: evt_buf_afl = %b, expected 1", $time, evt_buf_afl);
				errors++;
			end
			if (hi <= EVT_AMT_LVL && hi_prev <= EVT_AMT_LVL && !evt_buf_amt) begin
				$display("** Error at %0t: evt_buf_amt = %b, expected 1", $time, evt_buf_amt);
				errors++;
			end
			hi_prev = hi;
			if (txd_vld && txack) begin
				if (exp_q.size() == 0 && l1a_q.size() != 0 && samp_q.size() > samp_max)
					build_frame();
				if (exp_q.size() == 0) begin
					$display("word %h sent at %0t with no complete event queued", txd, $time);
					errors++;
				end else begin
					exp = exp_q.pop_front();
					if (txd !== exp[15:0]) begin
						$display("** Error at %0t: txd = %h, expected %h", $time, txd, exp[15:0]);
						errors++;
					end
					owed = owed - exp[16];
					if (exp_q.size() == 0)
						frames_done <= frames_done + 1;
				end
			end
			if (wren)
				samp_q.push_back(wdata);
			if (l1a_wren)
				l1a_q.push_back(l1a_data);
		end
	end

endmodule

`default_nettype wire

// File: tests/eth_readout_properties.sv
`default_nettype none
`timescale 1ns/1ps

module eth_readout_properties (
	input logic RCLK,
	input logic RST_RESYNC,
	input logic [15:0] txd,
	input logic txd_vld,
	input logic txack,
	input logic wren,
	input logic l1a_wren,
	input logic evt_full,
	input logic l1a_full
);

	logic trig_seen; // an l1a record was written since reset
	int fails = 0;

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC)
			trig_seen <= 1'b0;
		else if (l1a_wren)
			trig_seen <= 1'b1;
	end

	// word on the bus holds through a stall
	assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		txd_vld && !txack |=> txd_vld && $stable(txd))
		else begin
			$error("txd changed while txack was low");
			fails++;
		end

	// no word leaves before the first trigger record
	assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		!trig_seen |-> !txd_vld)
		else begin
			$error("txd_vld high before any l1a record was written");
			fails++;
		end

	assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		!(wren && evt_full) && !(l1a_wren && l1a_full))
		else begin
			$error("push into a full fifo");
			fails++;
		end

endmodule

bind eth_readout eth_readout_properties props (
	.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
	.txd(txd), .txd_vld(txd_vld), .txack(txack),
	.wren(wren), .l1a_wren(l1a_wren),
	.evt_full(evt_if.full), .l1a_full(l1a_if.full)
);

`default_nettype wire

// File: tests/tb_eth_readout.sv
`default_nettype none
`timescale 1ns/1ps

module tb_eth_readout import eth_pkg::*; ();

	localparam int TMO = 20000;

	logic RCLK = 1'b0;
	logic RST_RESYNC;
	logic [6:0] samp_max;
	logic [12:0] wdata;
	logic wren;
	logic [24:0] l1a_data;
	logic l1a_wren;
	logic warn;
	logic txack;
	logic [15:0] txd;
	logic txd_vld;
	logic evt_buf_amt;
	logic evt_buf_afl;
	int seed = 6;
	int l1a_pushed;
	int tb_errors;
	int chk_errors;
	int frames_done;
	logic txack_low; // transmitter stalled
	logic [23:0] l1a_num;

	always #4 RCLK = ~RCLK;

	eth_readout dut (.*);

	eth_readout_checker chk (.*, .errors(chk_errors));

	always @(posedge RCLK) begin
		if (txack_low)
			txack <= 1'b0;
		else
			txack <= ($random(seed) & 3) != 0; // low about one cycle in four
	end

	// samples first, then the trigger record
	task automatic push_event();
		int r;
		for (int i = 0; i <= samp_max; i++) begin
			@(posedge RCLK);
			r = $random(seed);
			wren <= 1'b1;
			wdata <= r[12:0];
		end
		r = $random(seed);
		l1a_num = l1a_num + r[3:0] + 24'd1;
		@(posedge RCLK);
		wren <= 1'b0;
		l1a_wren <= 1'b1;
		l1a_data <= {r[4], l1a_num};
		@(posedge RCLK);
		l1a_wren <= 1'b0;
		l1a_pushed++;
	endtask

	// idle=1 waits for every frame to leave, idle=0 for room in both fifos
	task automatic wait_frames(input bit idle);
		int t;
		int pend;
		t = 0;
		pend = l1a_pushed - frames_done;
		while (t < TMO && (idle ? pend != 0 :
				pend >= L1A_DEPTH || (pend + 1) * (samp_max + 1) > EVT_DEPTH)) begin
			@(posedge RCLK);
			t++;
			pend = l1a_pushed - frames_done;
		end
		if (t >= TMO) begin
			$display("timeout at %0t waiting for %s", $time, idle ? "frames to drain" : "fifo room");
			tb_errors++;
		end
	endtask

	initial begin
		int r;
		int n;
		RST_RESYNC = 1'b1;
		samp_max = 7'd28;
		wdata = '0;
		wren = 1'b0;
		l1a_data = '0;
		l1a_wren = 1'b0;
		warn = 1'b0;
		txack = 1'b0;
		txack_low = 1'b1;
		r = $random(seed);
		l1a_num = r[23:0];
		repeat (2) @(posedge RCLK);
		RST_RESYNC <= 1'b0;
		repeat (4) push_event(); // 116 samples, past almost full
		repeat (4) @(posedge RCLK);
		txack_low <= 1'b0;
		wait_frames(1'b1);
		for (int b = 0; b < 16 && tb_errors == 0; b++) begin
			r = $random(seed);
			samp_max <= (b % 4 == 3) ? r[6:0] : r[3:0];
			warn <= r[7];
			@(posedge RCLK);
			n = 1 + r[10:8];
			repeat (n) begin
				wait_frames(1'b0);
				push_event();
			end
			wait_frames(1'b1);
		end
		repeat (2) @(posedge RCLK);
		if (!evt_buf_amt) begin
			$display("** Error at %0t: evt_buf_amt = %b, expected 1", $time, evt_buf_amt);
			tb_errors++;
		end
		$display("errors: %0d checker, %0d testbench, %0d assertion",
			chk_errors, tb_errors, dut.props.fails);
		if (chk_errors == 0 && tb_errors == 0 && dut.props.fails == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
